// File: vlog.f
+incdir+common
+incdir+sim
common/isa_pkg.sv
common/pipe_pkg.sv
src/alu.sv
src/control_unit.sv
src/hazard_unit.sv
src/reg_file.sv
src/inst_mem.sv
src/data_ram.sv
src/pcpu_top.sv
sim/tb_pcpu.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_pcpu
OBJ_DIR   ?= obj_dir
FILELIST  ?= vlog.f
VFLAGS    ?= --binary --timing --assert

SRCS := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
HDRS := $(wildcard common/*.svh sim/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'sim passed'

clean:
	rm -rf $(OBJ_DIR)

// File: sim/tb_helpers.svh
`ifndef TB_HELPERS_SVH
`define TB_HELPERS_SVH

////////////////////////////////////////
// Instruction encoders
////////////////////////////////////////

// Register form, rs unused by shifts
function automatic isa_pkg::word_t enc_r(
	input isa_pkg::funct_t    fn,
	input isa_pkg::reg_addr_t rd,
	input isa_pkg::reg_addr_t rs,
	input isa_pkg::reg_addr_t rt,
	input logic [4:0]         shamt
);
	return {isa_pkg::OP_RTYPE, rs, rt, rd, shamt, fn};
endfunction

// Immediate form, rt is the destination or store data
function automatic isa_pkg::word_t enc_i(
	input isa_pkg::opcode_t   op,
	input isa_pkg::reg_addr_t rt,
	input isa_pkg::reg_addr_t rs,
	input logic [15:0]        imm
);
	return {op, rs, rt, imm};
endfunction

// Jump form from a byte address
function automatic isa_pkg::word_t enc_j(input isa_pkg::opcode_t op, input isa_pkg::word_t target);
	return {op, target[27:2]};
endfunction

// j-to-self at the next free slot
task automatic push_halt(output isa_pkg::word_t halt_pc);
	halt_pc = isa_pkg::word_t'(prog.size() * 4);
	prog.push_back(enc_j(isa_pkg::OP_J, halt_pc));
endtask

////////////////////////////////////////
// Program load and run
////////////////////////////////////////

task automatic load_and_release();
	int i;
	@(posedge clk_cpu);
	#2;
	rst = 1'b1;
	// One word per edge while the core sits in reset
	for (i = 0; i < prog.size(); i++) begin
		imem_we    = 1'b1;
		imem_addr  = i[`CPU_IMEM_AW-1:0];
		imem_wdata = prog[i];
		@(posedge clk_cpu);
		#2;
	end
	imem_we = 1'b0;
	repeat (2) @(posedge clk_cpu);
	#2;
	rst = 1'b0;
	// First cycle out of reset
	@(negedge clk_cpu);
	released_pc = fetch_pc;
endtask

// Poll for the halt loop, then let the pipe empty
task automatic wait_halt(input string name, input isa_pkg::word_t halt_pc);
	int n;
	bit seen;
	seen = 1'b0;
	for (n = 0; n < HALT_TIMEOUT && !seen; n++) begin
		@(negedge clk_cpu);
		seen = (fetch_pc == halt_pc);
	end
	if (!seen) begin
		$display("%s: program never reached its halt loop at %h", name, halt_pc);
		stop_on_failure();
	end
	repeat (`CPU_DRAIN) @(posedge clk_cpu);
endtask

task automatic run_program(input string name, input isa_pkg::word_t halt_pc);
	load_and_release();
	wait_halt(name, halt_pc);
endtask

////////////////////////////////////////
// Register read and compares
////////////////////////////////////////

task automatic read_reg(input isa_pkg::reg_addr_t r, output isa_pkg::word_t val);
	@(posedge clk_cpu);
	#2;
	dbg_reg_addr = r;
	@(negedge clk_cpu);
	val = dbg_reg_data;
endtask

task automatic check_reg(input string name, input isa_pkg::reg_addr_t r,
	input isa_pkg::word_t want);
	isa_pkg::word_t got;
	read_reg(r, got);
	if (got !== want) begin
		$display("error %s r%0d expected %h actual %h", name, r, want, got);
		stop_on_failure();
	end
endtask

task automatic check_pc(input string name, input isa_pkg::word_t want,
	input isa_pkg::word_t got);
	if (got !== want) begin
		$display("error %s pc expected %h actual %h", name, want, got);
		stop_on_failure();
	end
endtask

`endif

// File: sim/tb_pcpu.sv
`timescale 1ns/100ps
`include "cpu_config.svh"

module tb_pcpu;

	// Cycles allowed to reach a halt loop
	localparam int HALT_TIMEOUT = 300;
	localparam isa_pkg::word_t LFSR_SEED = 32'd41099;
	// Taps for x^32 + x^22 + x^2 + x + 1
	localparam isa_pkg::word_t LFSR_POLY = 32'h8020_0003;

	logic                    clk_cpu;
	logic                    rst;
	logic                    imem_we;
	logic [`CPU_IMEM_AW-1:0] imem_addr;
	isa_pkg::word_t          imem_wdata;
	isa_pkg::reg_addr_t      dbg_reg_addr;
	isa_pkg::word_t          dbg_reg_data;
	isa_pkg::word_t          fetch_pc;

	// Program under construction
	isa_pkg::word_t prog[$];
	isa_pkg::word_t released_pc;
	isa_pkg::word_t lfsr;

	pcpu_top u_pcpu_top (
		.clk_cpu      (clk_cpu),
		.rst          (rst),
		.imem_we      (imem_we),
		.imem_addr    (imem_addr),
		.imem_wdata   (imem_wdata),
		.dbg_reg_addr (dbg_reg_addr),
		.dbg_reg_data (dbg_reg_data),
		.fetch_pc     (fetch_pc)
	);

	// 40 ns period
	always #20 clk_cpu = ~clk_cpu;

	task automatic stop_on_failure();
		$display("sim failed");
		$fatal(1);
	endtask

	`include "tb_helpers.svh"

	////////////////////////////////////////
	// Random source
	////////////////////////////////////////

	function automatic isa_pkg::word_t galois_step(input isa_pkg::word_t s);
		return s[0] ? ((s >> 1) ^ LFSR_POLY) : (s >> 1);
	endfunction

	// One step per bit, msb first
	task automatic take_bits(input int n, output isa_pkg::word_t w);
		int k;
		w = '0;
		for (k = 0; k < n; k++) begin
			w = {w[30:0], lfsr[0]};
			lfsr = galois_step(lfsr);
		end
	endtask

	////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////

	task automatic test_alu();
		isa_pkg::word_t a;
		isa_pkg::word_t b;
		isa_pkg::word_t t;
		isa_pkg::word_t halt;
		isa_pkg::word_t want [1:11];
		logic [4:0]     s1;
		logic [4:0]     s2;
		logic [15:0]    imm1;
		logic [15:0]    imm2;
		int             r;
		take_bits(32, a);
		take_bits(32, b);
		take_bits(5, t);
		s1 = t[4:0];
		take_bits(5, t);
		s2 = t[4:0];
		take_bits(16, t);
		imm1 = t[15:0];
		take_bits(16, t);
		imm2 = t[15:0];
		prog.delete();
		// Operands built in halves, ori takes lui from execute
		prog.push_back(enc_i(isa_pkg::OP_LUI, 5'd1, 5'd0, a[31:16]));
		prog.push_back(enc_i(isa_pkg::OP_ORI, 5'd1, 5'd1, a[15:0]));
		prog.push_back(enc_i(isa_pkg::OP_LUI, 5'd2, 5'd0, b[31:16]));
		prog.push_back(enc_i(isa_pkg::OP_ORI, 5'd2, 5'd2, b[15:0]));
		// Each step feeds the next one or two
		prog.push_back(enc_r(isa_pkg::FN_ADD, 5'd3, 5'd1, 5'd2, 5'd0));
		prog.push_back(enc_r(isa_pkg::FN_SUB, 5'd4, 5'd1, 5'd2, 5'd0));
		prog.push_back(enc_r(isa_pkg::FN_AND, 5'd5, 5'd3, 5'd4, 5'd0));
		prog.push_back(enc_r(isa_pkg::FN_OR, 5'd6, 5'd4, 5'd5, 5'd0));
		prog.push_back(enc_r(isa_pkg::FN_SLT, 5'd7, 5'd5, 5'd6, 5'd0));
		prog.push_back(enc_r(isa_pkg::FN_SLL, 5'd8, 5'd0, 5'd6, s1));
		prog.push_back(enc_r(isa_pkg::FN_SRL, 5'd9, 5'd0, 5'd8, s2));
		prog.push_back(enc_i(isa_pkg::OP_ADDI, 5'd10, 5'd9, imm1));
		prog.push_back(enc_i(isa_pkg::OP_ANDI, 5'd11, 5'd10, imm2));
		push_halt(halt);
		// Reference results
		want[1]  = a;
		want[2]  = b;
		want[3]  = a + b;
		want[4]  = a - b;
		want[5]  = want[3] & want[4];
		want[6]  = want[4] | want[5];
		want[7]  = {31'd0, ($signed(want[5]) < $signed(want[6]))};
		want[8]  = want[6] << s1;
		want[9]  = want[8] >> s2;
		// addi sign extends, andi zero extends
		want[10] = want[9] + {{16{imm1[15]}}, imm1};
		want[11] = want[10] & {16'd0, imm2};
		run_program("alu", halt);
		for (r = 1; r <= 11; r++) begin
			check_reg("alu", isa_pkg::reg_addr_t'(r), want[r]);
		end
	endtask

	task automatic test_memory();
		isa_pkg::word_t v0;
		isa_pkg::word_t v1;
		isa_pkg::word_t v2;
		isa_pkg::word_t halt;
		take_bits(32, v0);
		take_bits(32, v1);
		take_bits(32, v2);
		prog.delete();
		prog.push_back(enc_i(isa_pkg::OP_ADDI, 5'd1, 5'd0, 16'h0040));
		prog.push_back(enc_i(isa_pkg::OP_LUI, 5'd2, 5'd0, v0[31:16]));
		prog.push_back(enc_i(isa_pkg::OP_ORI, 5'd2, 5'd2, v0[15:0]));
		prog.push_back(enc_i(isa_pkg::OP_LUI, 5'd3, 5'd0, v1[31:16]));
		prog.push_back(enc_i(isa_pkg::OP_ORI, 5'd3, 5'd3, v1[15:0]));
		prog.push_back(enc_i(isa_pkg::OP_LUI, 5'd4, 5'd0, v2[31:16]));
		prog.push_back(enc_i(isa_pkg::OP_ORI, 5'd4, 5'd4, v2[15:0]));
		// First store takes its data straight from execute
		prog.push_back(enc_i(isa_pkg::OP_SW, 5'd4, 5'd1, 16'd8));
		prog.push_back(enc_i(isa_pkg::OP_SW, 5'd2, 5'd1, 16'd0));
		prog.push_back(enc_i(isa_pkg::OP_SW, 5'd3, 5'd1, 16'd4));
		// Load then consumer, stall on rs and then on rt
		prog.push_back(enc_i(isa_pkg::OP_LW, 5'd5, 5'd1, 16'd0));
		prog.push_back(enc_r(isa_pkg::FN_ADD, 5'd6, 5'd5, 5'd5, 5'd0));
		prog.push_back(enc_i(isa_pkg::OP_LW, 5'd7, 5'd1, 16'd4));
		prog.push_back(enc_r(isa_pkg::FN_ADD, 5'd8, 5'd2, 5'd7, 5'd0));
		prog.push_back(enc_i(isa_pkg::OP_LW, 5'd9, 5'd1, 16'd8));
		prog.push_back(enc_r(isa_pkg::FN_ADD, 5'd10, 5'd9, 5'd3, 5'd0));
		push_halt(halt);
		run_program("memory", halt);
		check_reg("memory", 5'd1, 32'h0000_0040);
		check_reg("memory", 5'd5, v0);
		check_reg("memory", 5'd6, v0 + v0);
		check_reg("memory", 5'd7, v1);
		check_reg("memory", 5'd8, v0 + v1);
		check_reg("memory", 5'd9, v2);
		check_reg("memory", 5'd10, v2 + v1);
	endtask

	task automatic test_branch();
		isa_pkg::word_t halt;
		prog.delete();
		prog.push_back(enc_i(isa_pkg::OP_ADDI, 5'd1, 5'd0, 16'd5));
		prog.push_back(enc_i(isa_pkg::OP_ADDI, 5'd2, 5'd0, 16'd5));
		// Equal, skips one marker
		prog.push_back(enc_i(isa_pkg::OP_BEQ, 5'd2, 5'd1, 16'd1));
		prog.push_back(enc_i(isa_pkg::OP_ADDI, 5'd10, 5'd0, 16'd1));
		prog.push_back(enc_i(isa_pkg::OP_ADDI, 5'd3, 5'd0, 16'd7));
		// 7 vs 5, taken
		prog.push_back(enc_i(isa_pkg::OP_BNE, 5'd1, 5'd3, 16'd1));
		prog.push_back(enc_i(isa_pkg::OP_ADDI, 5'd11, 5'd0, 16'd1));
		// Not taken, next one must run
		prog.push_back(enc_i(isa_pkg::OP_BEQ, 5'd1, 5'd3, 16'd1));
		prog.push_back(enc_i(isa_pkg::OP_ADDI, 5'd4, 5'd0, 16'd9));
		prog.push_back(enc_i(isa_pkg::OP_BNE, 5'd2, 5'd1, 16'd1));
		prog.push_back(enc_i(isa_pkg::OP_ADDI, 5'd5, 5'd0, 16'd11));
		push_halt(halt);
		run_program("branch", halt);
		check_reg("branch", 5'd10, (32'd5 == 32'd5) ? 32'd0 : 32'd1);
		check_reg("branch", 5'd11, (32'd7 != 32'd5) ? 32'd0 : 32'd1);
		check_reg("branch", 5'd3, 32'd7);
		check_reg("branch", 5'd4, 32'd9);
		check_reg("branch", 5'd5, 32'd11);
	endtask

	task automatic test_jump();
		isa_pkg::word_t halt;
		isa_pkg::word_t jal_pc;
		prog.delete();
		prog.push_back(enc_i(isa_pkg::OP_ADDI, 5'd1, 5'd0, 16'd3));
		jal_pc = isa_pkg::word_t'(prog.size() * 4);
		prog.push_back(enc_j(isa_pkg::OP_JAL, 32'd16));
		// Return point, accumulates so a double run shows
		prog.push_back(enc_i(isa_pkg::OP_ADDI, 5'd2, 5'd2, 16'd10));
		push_halt(halt);
		// Subroutine at word 4
		prog.push_back(enc_i(isa_pkg::OP_ADDI, 5'd3, 5'd1, 16'd1));
		prog.push_back(enc_r(isa_pkg::FN_JR, 5'd0, 5'd31, 5'd0, 5'd0));
		prog.push_back(enc_i(isa_pkg::OP_ADDI, 5'd12, 5'd0, 16'd1));
		run_program("jump", halt);
		check_reg("jump", 5'd31, jal_pc + 32'd4);
		check_reg("jump", 5'd2, 32'd10);
		check_reg("jump", 5'd3, 32'd4);
		check_reg("jump", 5'd12, 32'd0);
	endtask

	task automatic test_reg_zero();
		isa_pkg::word_t halt;
		prog.delete();
		// r0 writes in flight must never forward
		prog.push_back(enc_i(isa_pkg::OP_LUI, 5'd0, 5'd0, 16'h1234));
		prog.push_back(enc_i(isa_pkg::OP_ORI, 5'd1, 5'd0, 16'h0000));
		prog.push_back(enc_i(isa_pkg::OP_ADDI, 5'd0, 5'd0, 16'd55));
		prog.push_back(enc_i(isa_pkg::OP_ADDI, 5'd2, 5'd0, 16'd1));
		prog.push_back(enc_r(isa_pkg::FN_ADD, 5'd0, 5'd2, 5'd2, 5'd0));
		prog.push_back(enc_r(isa_pkg::FN_ADD, 5'd3, 5'd0, 5'd2, 5'd0));
		push_halt(halt);
		run_program("reg0", halt);
		check_pc("reg0", 32'd0, released_pc);
		check_reg("reg0", 5'd0, 32'd0);
		check_reg("reg0", 5'd1, 32'd0);
		check_reg("reg0", 5'd2, 32'd1);
		check_reg("reg0", 5'd3, 32'd1);
	endtask

	////////////////////////////////////////
	// Sequence
	////////////////////////////////////////

	initial begin
		clk_cpu      = 1'b0;
		rst          = 1'b1;
		imem_we      = 1'b0;
		imem_addr    = '0;
		imem_wdata   = '0;
		dbg_reg_addr = '0;
		lfsr         = LFSR_SEED;
		// Power-on reset, two cycles
		repeat (2) @(posedge clk_cpu);
		test_alu();
		test_memory();
		test_branch();
		test_jump();
		test_reg_zero();
		$display("sim passed");
		$finish;
	end

endmodule

// File: src/pcpu_top.sv
`timescale 1ns/100ps
`include "cpu_config.svh"

module pcpu_top (
	input  logic                    clk_cpu,
	input  logic                    rst,
	input  logic                    imem_we,
	input  logic [`CPU_IMEM_AW-1:0] imem_addr,
	input  isa_pkg::word_t          imem_wdata,
	input  isa_pkg::reg_addr_t      dbg_reg_addr,
	output isa_pkg::word_t          dbg_reg_data,
	output isa_pkg::word_t          fetch_pc
);

	// Fetch
	isa_pkg::word_t      if_pc4;
	isa_pkg::word_t      if_instr;
	isa_pkg::word_t      pc_next;
	// IF/ID
	isa_pkg::instr_u     id_instr;
	isa_pkg::word_t      id_pc4;
	// Decode controls
	logic                id_reg_we;
	logic                id_mem_we;
	pipe_pkg::alu_op_t   id_alu_op;
	logic                id_alu_src_imm;
	logic                id_alu_src_shamt;
	logic                id_sign_ext;
	pipe_pkg::wb_sel_t   id_wb_sel;
	pipe_pkg::dest_sel_t id_dest_sel;
	logic                id_is_jal;
	pipe_pkg::pc_sel_t   id_pc_sel;
	logic                id_uses_rs;
	logic                id_uses_rt;
	pipe_pkg::fwd_sel_t  rs_fwd;
	pipe_pkg::fwd_sel_t  rt_fwd;
	logic                stall_load;
	logic                flush;
	// Decode datapath
	isa_pkg::word_t      id_rs_rf;
	isa_pkg::word_t      id_rt_rf;
	isa_pkg::word_t      id_rs_val;
	isa_pkg::word_t      id_rt_val;
	isa_pkg::word_t      id_op_b;
	isa_pkg::word_t      id_imm_ext;
	isa_pkg::word_t      id_br_target;
	isa_pkg::word_t      id_j_target;
	isa_pkg::reg_addr_t  id_dest;
	logic                ops_equal;
	// ID/EX
	logic                ex_reg_we;
	logic                ex_mem_we;
	pipe_pkg::alu_op_t   ex_alu_op;
	logic                ex_alu_src_imm;
	logic                ex_alu_src_shamt;
	pipe_pkg::wb_sel_t   ex_wb_sel;
	isa_pkg::word_t      ex_rs_val;
	isa_pkg::word_t      ex_rt_val;
	isa_pkg::word_t      ex_imm_ext;
	logic [4:0]          ex_shamt;
	isa_pkg::reg_addr_t  ex_dest;
	// Execute
	isa_pkg::word_t      ex_a;
	isa_pkg::word_t      ex_b;
	isa_pkg::word_t      ex_alu_res;
	isa_pkg::word_t      ex_result;
	// EX/MEM
	logic                mem_reg_we;
	logic                mem_mem_we;
	pipe_pkg::wb_sel_t   mem_wb_sel;
	isa_pkg::word_t      mem_result;
	isa_pkg::word_t      mem_st_data;
	isa_pkg::reg_addr_t  mem_dest;
	isa_pkg::word_t      mem_rdata;
	// MEM/WB
	logic                wb_reg_we;
	pipe_pkg::wb_sel_t   wb_wb_sel;
	isa_pkg::word_t      wb_result;
	isa_pkg::word_t      wb_rdata;
	isa_pkg::reg_addr_t  wb_dest;
	isa_pkg::word_t      wb_wdata;

	// Operand source pick for decode
	function automatic isa_pkg::word_t fwd_mux(
		input pipe_pkg::fwd_sel_t sel,
		input isa_pkg::word_t     rf_val,
		input isa_pkg::word_t     ex_val,
		input isa_pkg::word_t     mem_val,
		input isa_pkg::word_t     mem_ld
	);
		case (sel)
			pipe_pkg::FWD_EX_ALU:   return ex_val;
			pipe_pkg::FWD_MEM_ALU:  return mem_val;
			pipe_pkg::FWD_MEM_DATA: return mem_ld;
			default:                return rf_val;
		endcase
	endfunction

	////////////////////////////////////////
	// Fetch
	////////////////////////////////////////

	assign if_pc4 = fetch_pc + 4;

	// Redirects come from decode
	always_comb begin
		case (id_pc_sel)
			pipe_pkg::PC_JUMP:   pc_next = id_j_target;
			pipe_pkg::PC_BRANCH: pc_next = id_br_target;
			pipe_pkg::PC_REG:    pc_next = id_rs_val;
			default:             pc_next = if_pc4;
		endcase
	end

	// PC holds on load-use
	always_ff @(posedge clk_cpu or posedge rst) begin
		if (rst) begin
			fetch_pc <= '0;
		end else if (!stall_load) begin
			fetch_pc <= pc_next;
		end
	end

	inst_mem u_inst_mem (
		.clk_cpu (clk_cpu),
		.rst     (rst),
		.we      (imem_we),
		.waddr   (imem_addr),
		.wdata   (imem_wdata),
		.pc      (fetch_pc),
		.instr   (if_instr)
	);

	////////////////////////////////////////
	// IF/ID
	////////////////////////////////////////

	// Taken redirect kills the fetched slot, unless decode waits on a load
	assign flush = (id_pc_sel != pipe_pkg::PC_SEQ) && !stall_load;

	always_ff @(posedge clk_cpu or posedge rst) begin
		if (rst) begin
			id_instr <= '0;
		end else if (stall_load) begin
			id_instr <= id_instr;
		end else if (flush) begin
			id_instr <= '0;
		end else begin
			id_instr <= if_instr;
		end
	end

	always_ff @(posedge clk_cpu) begin
		if (!stall_load) begin
			id_pc4 <= if_pc4;
		end
	end

	// A cleared slot decodes as a nop and is never held for a load
	flushed_slot_not_held: assert property (@(posedge clk_cpu) disable iff (rst)
		flush |=> !stall_load);

	////////////////////////////////////////
	// Decode
	////////////////////////////////////////

	control_unit u_control_unit (
		.instr         (id_instr),
		.ops_equal     (ops_equal),
		.reg_we        (id_reg_we),
		.mem_we        (id_mem_we),
		.alu_op        (id_alu_op),
		.alu_src_imm   (id_alu_src_imm),
		.alu_src_shamt (id_alu_src_shamt),
		.sign_ext      (id_sign_ext),
		.wb_sel        (id_wb_sel),
		.dest_sel      (id_dest_sel),
		.is_jal        (id_is_jal),
		.pc_sel        (id_pc_sel),
		.uses_rs       (id_uses_rs),
		.uses_rt       (id_uses_rt)
	);

	hazard_unit u_hazard_unit (
		.rs         (id_instr.r.rs),
		.rt         (id_instr.r.rt),
		.uses_rs    (id_uses_rs),
		.uses_rt    (id_uses_rt),
		.ex_dest    (ex_dest),
		.ex_reg_we  (ex_reg_we),
		.ex_wb_sel  (ex_wb_sel),
		.mem_dest   (mem_dest),
		.mem_reg_we (mem_reg_we),
		.mem_wb_sel (mem_wb_sel),
		.rs_fwd     (rs_fwd),
		.rt_fwd     (rt_fwd),
		.stall_load (stall_load)
	);

	reg_file u_reg_file (
		.clk_cpu   (clk_cpu),
		.rst       (rst),
		.we        (wb_reg_we),
		.waddr     (wb_dest),
		.wdata     (wb_wdata),
		.raddr_a   (id_instr.r.rs),
		.raddr_b   (id_instr.r.rt),
		.raddr_dbg (dbg_reg_addr),
		.rdata_a   (id_rs_rf),
		.rdata_b   (id_rt_rf),
		.rdata_dbg (dbg_reg_data)
	);

	// Forwarded operands, write-back handled by the register file
	assign id_rs_val = fwd_mux(rs_fwd, id_rs_rf, ex_result, mem_result, mem_rdata);
	assign id_rt_val = fwd_mux(rt_fwd, id_rt_rf, ex_result, mem_result, mem_rdata);
	assign ops_equal = (id_rs_val == id_rt_val);

	// jal carries its link through the B operand
	assign id_op_b = id_is_jal ? id_pc4 : id_rt_val;

	assign id_imm_ext = {{(`CPU_XLEN-16){id_sign_ext && id_instr.i.imm[15]}}, id_instr.i.imm};

	// Targets
	assign id_br_target = id_pc4 + {id_imm_ext[`CPU_XLEN-3:0], 2'b00};
	assign id_j_target  = {id_pc4[31:28], id_instr[25:0], 2'b00};

	always_comb begin
		case (id_dest_sel)
			pipe_pkg::DEST_RD: id_dest = id_instr.r.rd;
			pipe_pkg::DEST_RA: id_dest = '1;
			default:           id_dest = id_instr.r.rt;
		endcase
	end

	////////////////////////////////////////
	// ID/EX
	////////////////////////////////////////

	// Stall inserts a bubble
	always_ff @(posedge clk_cpu or posedge rst) begin
		if (rst) begin
			ex_reg_we        <= 1'b0;
			ex_mem_we        <= 1'b0;
			ex_alu_op        <= pipe_pkg::ALU_ADD;
			ex_alu_src_imm   <= 1'b0;
			ex_alu_src_shamt <= 1'b0;
			ex_wb_sel        <= pipe_pkg::WB_ALU;
		end else if (stall_load) begin
			ex_reg_we        <= 1'b0;
			ex_mem_we        <= 1'b0;
			ex_alu_op        <= pipe_pkg::ALU_ADD;
			ex_alu_src_imm   <= 1'b0;
			ex_alu_src_shamt <= 1'b0;
			ex_wb_sel        <= pipe_pkg::WB_ALU;
		end else begin
			ex_reg_we        <= id_reg_we;
			ex_mem_we        <= id_mem_we;
			ex_alu_op        <= id_alu_op;
			ex_alu_src_imm   <= id_alu_src_imm;
			ex_alu_src_shamt <= id_alu_src_shamt;
			ex_wb_sel        <= id_wb_sel;
		end
	end

	always_ff @(posedge clk_cpu) begin
		ex_rs_val  <= id_rs_val;
		ex_rt_val  <= id_op_b;
		ex_imm_ext <= id_imm_ext;
		ex_shamt   <= id_instr.r.shamt;
		ex_dest    <= id_dest;
	end

	////////////////////////////////////////
	// Execute
	////////////////////////////////////////

	assign ex_a = ex_alu_src_shamt ? isa_pkg::word_t'(ex_shamt) : ex_rs_val;
	assign ex_b = ex_alu_src_imm ? ex_imm_ext : ex_rt_val;

	alu u_alu (
		.a   (ex_a),
		.b   (ex_b),
		.op  (ex_alu_op),
		.res (ex_alu_res)
	);

	// lui merges here so it can be forwarded like any result
	assign ex_result = (ex_wb_sel == pipe_pkg::WB_LUI) ?
		{ex_imm_ext[15:0], {(`CPU_XLEN-16){1'b0}}} : ex_alu_res;

	////////////////////////////////////////
	// EX/MEM and memory
	////////////////////////////////////////

	always_ff @(posedge clk_cpu or posedge rst) begin
		if (rst) begin
			mem_reg_we <= 1'b0;
			mem_mem_we <= 1'b0;
			mem_wb_sel <= pipe_pkg::WB_ALU;
		end else begin
			mem_reg_we <= ex_reg_we;
			mem_mem_we <= ex_mem_we;
			mem_wb_sel <= ex_wb_sel;
		end
	end

	always_ff @(posedge clk_cpu) begin
		mem_result  <= ex_result;
		mem_st_data <= ex_rt_val;
		mem_dest    <= ex_dest;
	end

	data_ram u_data_ram (
		.clk_cpu (clk_cpu),
		.we      (mem_mem_we),
		.addr    (mem_result),
		.wdata   (mem_st_data),
		.rdata   (mem_rdata)
	);

	////////////////////////////////////////
	// MEM/WB and write-back
	////////////////////////////////////////

	always_ff @(posedge clk_cpu or posedge rst) begin
		if (rst) begin
			wb_reg_we <= 1'b0;
			wb_wb_sel <= pipe_pkg::WB_ALU;
		end else begin
			wb_reg_we <= mem_reg_we;
			wb_wb_sel <= mem_wb_sel;
		end
	end

	always_ff @(posedge clk_cpu) begin
		wb_result <= mem_result;
		wb_rdata  <= mem_rdata;
		wb_dest   <= mem_dest;
	end

	// Load data or merged ALU result
	assign wb_wdata = (wb_wb_sel == pipe_pkg::WB_MEM) ? wb_rdata : wb_result;

endmodule

// File: src/data_ram.sv
`timescale 1ns/100ps
`include "cpu_config.svh"

module data_ram (
	input  logic           clk_cpu,
	input  logic           we,
	input  isa_pkg::word_t addr,
	input  isa_pkg::word_t wdata,
	output isa_pkg::word_t rdata
);

	isa_pkg::word_t mem [2**`CPU_DMEM_AW];

	// Store on the edge
	always_ff @(posedge clk_cpu) begin
		if (we) begin
			mem[addr[`CPU_DMEM_AW+1:2]] <= wdata;
		end
	end

	// Load answers in the same cycle
	assign rdata = mem[addr[`CPU_DMEM_AW+1:2]];

endmodule

// File: src/inst_mem.sv
`timescale 1ns/100ps
`include "cpu_config.svh"

module inst_mem (
	input  logic                    clk_cpu,
	input  logic                    rst,
	input  logic                    we,
	input  logic [`CPU_IMEM_AW-1:0] waddr,
	input  isa_pkg::word_t          wdata,
	input  isa_pkg::word_t          pc,
	output isa_pkg::word_t          instr
);

	isa_pkg::word_t mem [2**`CPU_IMEM_AW];

	// Program load port
	always_ff @(posedge clk_cpu) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// Byte PC to word index
	assign instr = mem[pc[`CPU_IMEM_AW+1:2]];

	// Programs only change while the core is held in reset
	load_only_in_reset: assert property (@(posedge clk_cpu) we |-> rst);

endmodule

// File: src/reg_file.sv
`timescale 1ns/100ps
`include "cpu_config.svh"

module reg_file (
	input  logic               clk_cpu,
	input  logic               rst,
	input  logic               we,
	input  isa_pkg::reg_addr_t waddr,
	input  isa_pkg::word_t     wdata,
	input  isa_pkg::reg_addr_t raddr_a,
	input  isa_pkg::reg_addr_t raddr_b,
	input  isa_pkg::reg_addr_t raddr_dbg,
	output isa_pkg::word_t     rdata_a,
	output isa_pkg::word_t     rdata_b,
	output isa_pkg::word_t     rdata_dbg
);

	// No storage for r0
	isa_pkg::word_t regs [1:2**`CPU_REG_AW-1];

	always_ff @(posedge clk_cpu or posedge rst) begin
		if (rst) begin
			for (int i = 1; i < 2**`CPU_REG_AW; i++) begin
				regs[i] <= '0;
			end
		end else if (we && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	// Write-through so decode sees the value retiring this cycle
	function automatic isa_pkg::word_t rd_port(input isa_pkg::reg_addr_t addr);
		if (addr == '0) begin
			return '0;
		end
		if (we && waddr == addr) begin
			return wdata;
		end
		return regs[addr];
	endfunction

	always_comb begin
		rdata_a   = rd_port(raddr_a);
		rdata_b   = rd_port(raddr_b);
		rdata_dbg = rd_port(raddr_dbg);
	end

endmodule

// File: src/hazard_unit.sv
`timescale 1ns/100ps

module hazard_unit (
	input  isa_pkg::reg_addr_t rs,
	input  isa_pkg::reg_addr_t rt,
	input  logic               uses_rs,
	input  logic               uses_rt,
	input  isa_pkg::reg_addr_t ex_dest,
	input  logic               ex_reg_we,
	input  pipe_pkg::wb_sel_t  ex_wb_sel,
	input  isa_pkg::reg_addr_t mem_dest,
	input  logic               mem_reg_we,
	input  pipe_pkg::wb_sel_t  mem_wb_sel,
	output pipe_pkg::fwd_sel_t rs_fwd,
	output pipe_pkg::fwd_sel_t rt_fwd,
	output logic               stall_load
);

	logic ex_is_load;

	// Youngest producer wins, r0 never forwards
	function automatic pipe_pkg::fwd_sel_t pick(input isa_pkg::reg_addr_t src);
		pipe_pkg::fwd_sel_t sel;
		sel = pipe_pkg::FWD_RF;
		if (src != '0) begin
			if (ex_reg_we && ex_dest == src) begin
				sel = pipe_pkg::FWD_EX_ALU;
			end else if (mem_reg_we && mem_dest == src) begin
				sel = (mem_wb_sel == pipe_pkg::WB_MEM) ?
					pipe_pkg::FWD_MEM_DATA : pipe_pkg::FWD_MEM_ALU;
			end
		end
		return sel;
	endfunction

	assign ex_is_load = ex_reg_we && (ex_wb_sel == pipe_pkg::WB_MEM) && (ex_dest != '0);

	always_comb begin
		rs_fwd = pick(rs);
		rt_fwd = pick(rt);
		// Load data not ready until the memory stage
		stall_load = ex_is_load &&
			((uses_rs && ex_dest == rs) || (uses_rt && ex_dest == rt));
	end

endmodule

// File: src/control_unit.sv
`timescale 1ns/100ps

module control_unit (
	input  isa_pkg::instr_u     instr,
	input  logic                ops_equal,
	output logic                reg_we,
	output logic                mem_we,
	output pipe_pkg::alu_op_t   alu_op,
	output logic                alu_src_imm,
	output logic                alu_src_shamt,
	output logic                sign_ext,
	output pipe_pkg::wb_sel_t   wb_sel,
	output pipe_pkg::dest_sel_t dest_sel,
	output logic                is_jal,
	output pipe_pkg::pc_sel_t   pc_sel,
	output logic                uses_rs,
	output logic                uses_rt
);

	always_comb begin
		// Defaults describe a nop
		reg_we        = 1'b0;
		mem_we        = 1'b0;
		alu_op        = pipe_pkg::ALU_ADD;
		alu_src_imm   = 1'b0;
		alu_src_shamt = 1'b0;
		sign_ext      = 1'b0;
		wb_sel        = pipe_pkg::WB_ALU;
		dest_sel      = pipe_pkg::DEST_RT;
		is_jal        = 1'b0;
		pc_sel        = pipe_pkg::PC_SEQ;
		uses_rs       = 1'b0;
		uses_rt       = 1'b0;

		case (instr.r.opcode)
			isa_pkg::OP_RTYPE: begin
				dest_sel = pipe_pkg::DEST_RD;
				uses_rs  = 1'b1;
				uses_rt  = 1'b1;
				// All-zero word decodes as sll and must not write
				reg_we   = (instr != '0);
				case (instr.r.funct)
					isa_pkg::FN_ADD: alu_op = pipe_pkg::ALU_ADD;
					isa_pkg::FN_SUB: alu_op = pipe_pkg::ALU_SUB;
					isa_pkg::FN_AND: alu_op = pipe_pkg::ALU_AND;
					isa_pkg::FN_OR:  alu_op = pipe_pkg::ALU_OR;
					isa_pkg::FN_SLT: alu_op = pipe_pkg::ALU_SLT;
					isa_pkg::FN_SLL: begin
						alu_op        = pipe_pkg::ALU_SLL;
						alu_src_shamt = 1'b1;
						uses_rs       = 1'b0;
					end
					isa_pkg::FN_SRL: begin
						alu_op        = pipe_pkg::ALU_SRL;
						alu_src_shamt = 1'b1;
						uses_rs       = 1'b0;
					end
					// Register jump, no write
					isa_pkg::FN_JR: begin
						reg_we  = 1'b0;
						uses_rt = 1'b0;
						pc_sel  = pipe_pkg::PC_REG;
					end
					default: reg_we = 1'b0;
				endcase
			end
			isa_pkg::OP_ADDI: begin
				reg_we      = 1'b1;
				alu_src_imm = 1'b1;
				sign_ext    = 1'b1;
				uses_rs     = 1'b1;
			end
			// Logical immediates zero extend
			isa_pkg::OP_ANDI: begin
				reg_we      = 1'b1;
				alu_src_imm = 1'b1;
				alu_op      = pipe_pkg::ALU_AND;
				uses_rs     = 1'b1;
			end
			isa_pkg::OP_ORI: begin
				reg_we      = 1'b1;
				alu_src_imm = 1'b1;
				alu_op      = pipe_pkg::ALU_OR;
				uses_rs     = 1'b1;
			end
			isa_pkg::OP_LUI: begin
				reg_we = 1'b1;
				wb_sel = pipe_pkg::WB_LUI;
			end
			isa_pkg::OP_LW: begin
				reg_we      = 1'b1;
				alu_src_imm = 1'b1;
				sign_ext    = 1'b1;
				wb_sel      = pipe_pkg::WB_MEM;
				uses_rs     = 1'b1;
			end
			isa_pkg::OP_SW: begin
				mem_we      = 1'b1;
				alu_src_imm = 1'b1;
				sign_ext    = 1'b1;
				uses_rs     = 1'b1;
				uses_rt     = 1'b1;
			end
			// Branches compare forwarded operands here in decode
			isa_pkg::OP_BEQ: begin
				sign_ext = 1'b1;
				uses_rs  = 1'b1;
				uses_rt  = 1'b1;
				pc_sel   = ops_equal ? pipe_pkg::PC_BRANCH : pipe_pkg::PC_SEQ;
			end
			isa_pkg::OP_BNE: begin
				sign_ext = 1'b1;
				uses_rs  = 1'b1;
				uses_rt  = 1'b1;
				pc_sel   = ops_equal ? pipe_pkg::PC_SEQ : pipe_pkg::PC_BRANCH;
			end
			isa_pkg::OP_J: pc_sel = pipe_pkg::PC_JUMP;
			// Link value passes through the ALU B side
			isa_pkg::OP_JAL: begin
				reg_we   = 1'b1;
				dest_sel = pipe_pkg::DEST_RA;
				is_jal   = 1'b1;
				alu_op   = pipe_pkg::ALU_PASS_B;
				pc_sel   = pipe_pkg::PC_JUMP;
			end
			default: ;
		endcase
	end

endmodule

// File: src/alu.sv
`timescale 1ns/100ps

module alu (
	input  isa_pkg::word_t    a,
	input  isa_pkg::word_t    b,
	input  pipe_pkg::alu_op_t op,
	output isa_pkg::word_t    res
);

	always_comb begin
		case (op)
			pipe_pkg::ALU_ADD:    res = a + b;
			pipe_pkg::ALU_SUB:    res = a - b;
			pipe_pkg::ALU_AND:    res = a & b;
			pipe_pkg::ALU_OR:     res = a | b;
			// Signed compare, result 0 or 1
			pipe_pkg::ALU_SLT:    res = isa_pkg::word_t'($signed(a) < $signed(b));
			// Shift amount sits in the low bits of A
			pipe_pkg::ALU_SLL:    res = b << a[4:0];
			pipe_pkg::ALU_SRL:    res = b >> a[4:0];
			pipe_pkg::ALU_PASS_B: res = b;
			default:              res = '0;
		endcase
	end

endmodule

// File: common/pipe_pkg.sv
package pipe_pkg;

	// ALU operation
	typedef enum logic [3:0] {
		ALU_ADD    = 4'd0,
		ALU_SUB    = 4'd1,
		ALU_AND    = 4'd2,
		ALU_OR     = 4'd3,
		ALU_SLT    = 4'd4,
		ALU_SLL    = 4'd5,
		ALU_SRL    = 4'd6,
		ALU_PASS_B = 4'd7
	} alu_op_t;

	// Result source for write-back
	typedef enum logic [1:0] {
		WB_ALU = 2'd0,
		WB_MEM = 2'd1,
		WB_LUI = 2'd2
	} wb_sel_t;

	// Decode operand source
	typedef enum logic [1:0] {
		FWD_RF       = 2'd0,
		FWD_EX_ALU   = 2'd1,
		FWD_MEM_ALU  = 2'd2,
		FWD_MEM_DATA = 2'd3
	} fwd_sel_t;

	// Destination register choice
	typedef enum logic [1:0] {
		DEST_RT = 2'd0,
		DEST_RD = 2'd1,
		DEST_RA = 2'd2
	} dest_sel_t;

	// Next PC source
	typedef enum logic [1:0] {
		PC_SEQ    = 2'd0,
		PC_JUMP   = 2'd1,
		PC_BRANCH = 2'd2,
		PC_REG    = 2'd3
	} pc_sel_t;

endpackage

// File: common/isa_pkg.sv
`include "cpu_config.svh"

package isa_pkg;

	// One machine word
	typedef logic [`CPU_XLEN-1:0] word_t;

	// Register number
	typedef logic [`CPU_REG_AW-1:0] reg_addr_t;

	////////////////////////////////////////
	// Opcodes and funct codes
	////////////////////////////////////////

	// Kept primary opcodes
	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_J     = 6'h02,
		OP_JAL   = 6'h03,
		OP_BEQ   = 6'h04,
		OP_BNE   = 6'h05,
		OP_ADDI  = 6'h08,
		OP_ANDI  = 6'h0c,
		OP_ORI   = 6'h0d,
		OP_LUI   = 6'h0f,
		OP_LW    = 6'h23,
		OP_SW    = 6'h2b
	} opcode_t;

	// Kept R-type funct codes
	typedef enum logic [5:0] {
		FN_SLL = 6'h00,
		FN_SRL = 6'h02,
		FN_JR  = 6'h08,
		FN_ADD = 6'h20,
		FN_SUB = 6'h22,
		FN_AND = 6'h24,
		FN_OR  = 6'h25,
		FN_SLT = 6'h2a
	} funct_t;

	////////////////////////////////////////
	// Instruction word views
	////////////////////////////////////////

	// Register form
	typedef struct packed {
		opcode_t    opcode;
		reg_addr_t  rs;
		reg_addr_t  rt;
		reg_addr_t  rd;
		logic [4:0] shamt;
		funct_t     funct;
	} r_fmt_t;

	// Immediate form
	typedef struct packed {
		opcode_t     opcode;
		reg_addr_t   rs;
		reg_addr_t   rt;
		logic [15:0] imm;
	} i_fmt_t;

	// Same word seen both ways, jump target is bits 25..0
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
	} instr_u;

endpackage

// File: common/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

////////////////////////////////////////
// Core widths
////////////////////////////////////////

// Data and address width
`define CPU_XLEN 32

// Register number width, 32 registers
`define CPU_REG_AW 5

////////////////////////////////////////
// Memory depths
////////////////////////////////////////

// Word address bits of instruction memory
`define CPU_IMEM_AW 8

// Word address bits of data memory
`define CPU_DMEM_AW 8

// Cycles to let the pipe empty after the halt loop
`define CPU_DRAIN 6

`endif
